// File: periph_cfg.svh
/*
 Peripheral block configuration.
 Tick and baud increments, FIFO depth and the register map.
*/
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// per-clock fraction of a microsecond whose carry out is one tick
`define PERIPH_TICK_INC 16'h4000
// fraction of a bit time added per microsecond
`define PERIPH_BAUD_INC 16'h4000
`define PERIPH_FIFO_DEPTH 8

// address bits 27:16 of the peripheral page
`define PERIPH_PAGE 12'h000

`define PERIPH_OFF_TIMERLO  16'hE000
`define PERIPH_OFF_TIMERHI  16'hE004
`define PERIPH_OFF_UARTDATA 16'hE010
`define PERIPH_OFF_UARTTX   16'hE014
`define PERIPH_OFF_UARTSTAT 16'hE018
`define PERIPH_OFF_BOUNCE   16'hE080
`define PERIPH_OFF_GPIOIN   16'hE100
`define PERIPH_OFF_GPIOOUT  16'hE104
`define PERIPH_OFF_GPIODIR  16'hE108
`define PERIPH_OFF_GPIOSET  16'hE110
`define PERIPH_OFF_GPIOCLR  16'hE114

`endif

// File: mmioPkg.sv
/*
 MMIO bus types.
 Request and response words of the strobe bus and its OK codes.
*/
`default_nettype none

package mmioPkg;

	// opm bit positions
	localparam int OPM_SIZE_LO = 0;
	localparam int OPM_SIZE_HI = 1;
	localparam int OPM_READ = 3;
	localparam int OPM_WRITE = 4;

	// size field value for a 64-bit access
	localparam logic [1:0] SIZE_QUAD = 2'd3;

	typedef enum logic [1:0]
	{
		READY = 2'b00,
		OK = 2'b01,
		HOLD = 2'b10
	} okCode_t;

	typedef struct packed
	{
		logic [63:0] data;
		logic [31:0] addr;
		logic [4:0] opm;
	} mmioReq_t;

	typedef struct packed
	{
		logic [63:0] data;
		okCode_t ok;
	} mmioRsp_t;

endpackage

`default_nettype wire

// File: periphPkg.sv
/*
 Peripheral types.
 Register select, the decoded operation passed to each block and UART status.
*/
`default_nettype none

package periphPkg;

	typedef enum logic [3:0]
	{
		NONE,
		TIMERLO,
		TIMERHI,
		UARTDATA,
		UARTTX,
		UARTSTAT,
		BOUNCE,
		GPIOIN,
		GPIOOUT,
		GPIODIR,
		GPIOSET,
		GPIOCLR
	} regSel_t;

	// one decoded access, registered once per cycle
	typedef struct packed
	{
		regSel_t sel;
		logic rdLevel;
		logic wrLevel;
		logic rdEdge;
		logic wrEdge;
		logic quad;
		logic [63:0] wdata;
	} regOp_t;

	typedef struct packed
	{
		logic txFull;
		logic txEmpty;
		logic rxFull;
		logic rxReady;
	} uartStat_t;

endpackage

`default_nettype wire

// File: mmioDecode.sv
/*
 MMIO request decoder.
 Registers the bus request, matches page and offset, and builds
 the access levels and first-cycle edges for the execute blocks.
*/
`default_nettype none
`timescale 1ns/1ps
`include "periph_cfg.svh"

module mmioDecode
(
	input wire logic clock,
	input wire logic reset,
	input mmioPkg::mmioReq_t mmioReq,
	output periphPkg::regOp_t op
);

	mmioPkg::mmioReq_t reqQ;
	periphPkg::regOp_t opNext;
	logic pageHit;

	always_ff @(posedge clock)
	begin
		reqQ.data <= mmioReq.data;
		reqQ.addr <= mmioReq.addr;
		if (reset)
			reqQ.opm <= '0;
		else
			reqQ.opm <= mmioReq.opm;
	end

	assign pageHit = (reqQ.addr[27:16] == `PERIPH_PAGE);

	always_comb
	begin
		opNext.sel = periphPkg::NONE;
		if (pageHit)
		begin
			case (reqQ.addr[15:0])
				`PERIPH_OFF_TIMERLO: opNext.sel = periphPkg::TIMERLO;
				`PERIPH_OFF_TIMERHI: opNext.sel = periphPkg::TIMERHI;
				`PERIPH_OFF_UARTDATA: opNext.sel = periphPkg::UARTDATA;
				`PERIPH_OFF_UARTTX: opNext.sel = periphPkg::UARTTX;
				`PERIPH_OFF_UARTSTAT: opNext.sel = periphPkg::UARTSTAT;
				`PERIPH_OFF_BOUNCE: opNext.sel = periphPkg::BOUNCE;
				`PERIPH_OFF_GPIOIN: opNext.sel = periphPkg::GPIOIN;
				`PERIPH_OFF_GPIOOUT: opNext.sel = periphPkg::GPIOOUT;
				`PERIPH_OFF_GPIODIR: opNext.sel = periphPkg::GPIODIR;
				`PERIPH_OFF_GPIOSET: opNext.sel = periphPkg::GPIOSET;
				`PERIPH_OFF_GPIOCLR: opNext.sel = periphPkg::GPIOCLR;
				default: opNext.sel = periphPkg::NONE;
			endcase
		end
		opNext.rdLevel = reqQ.opm[mmioPkg::OPM_READ] && pageHit;
		opNext.wrLevel = reqQ.opm[mmioPkg::OPM_WRITE] && pageHit;
		// op still holds last cycle's levels
		opNext.rdEdge = opNext.rdLevel && !op.rdLevel;
		opNext.wrEdge = opNext.wrLevel && !op.wrLevel;
		opNext.quad = (reqQ.opm[mmioPkg::OPM_SIZE_HI:mmioPkg::OPM_SIZE_LO]
			== mmioPkg::SIZE_QUAD);
		opNext.wdata = reqQ.data;
	end

	always_ff @(posedge clock)
	begin
		op.wdata <= opNext.wdata;
		if (reset)
		begin
			op.sel <= periphPkg::NONE;
			op.rdLevel <= 1'b0;
			op.wrLevel <= 1'b0;
			op.rdEdge <= 1'b0;
			op.wrEdge <= 1'b0;
			op.quad <= 1'b0;
		end
		else
		begin
			op.sel <= opNext.sel;
			op.rdLevel <= opNext.rdLevel;
			op.wrLevel <= opNext.wrLevel;
			op.rdEdge <= opNext.rdEdge;
			op.wrEdge <= opNext.wrEdge;
			op.quad <= opNext.quad;
		end
	end

	// an access held over several cycles keeps its register
	assert property (@(posedge clock) disable iff (reset)
		((op.rdLevel && !op.rdEdge) || (op.wrLevel && !op.wrEdge))
		|-> op.sel == $past(op.sel))
	else
		$error("register changed during a held access at %0t", $time);

endmodule

`default_nettype wire

// File: tickTimer.sv
/*
 Microsecond tick and timers.
 A fractional accumulator makes the microsecond tick; two 64-bit
 counters track microseconds and clocks.
*/
`default_nettype none
`timescale 1ns/1ps
`include "periph_cfg.svh"

module tickTimer
(
	input wire logic clock,
	input wire logic reset,
	output logic usTick,
	output logic [63:0] timer1MHz,
	output logic [63:0] timerCycles
);

	logic [15:0] fracAcc;
	logic [15:0] fracNext;
	logic carry;

	assign {carry, fracNext} = {1'b0, fracAcc} + 17'(`PERIPH_TICK_INC);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fracAcc <= '0;
			usTick <= 1'b0;
			timer1MHz <= '0;
			timerCycles <= '0;
		end
		else
		begin
			fracAcc <= fracNext;
			usTick <= carry;
			timerCycles <= timerCycles + 64'd1;
			if (usTick)
				timer1MHz <= timer1MHz + 64'd1;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		timer1MHz >= $past(timer1MHz))
	else
		$error("timer1MHz went backwards at %0t", $time);

endmodule

`default_nettype wire

// File: gpioPort.sv
/*
 GPIO port.
 Output and direction registers with set and clear access and readback.
*/
`default_nettype none
`timescale 1ns/1ps

module gpioPort
(
	input wire logic clock,
	input wire logic reset,
	input periphPkg::regOp_t op,
	output logic [31:0] gpioOut,
	output logic [31:0] gpioDir,
	output logic [31:0] gpioRead
);

	// a held write loads the same value on every cycle of its level
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			gpioOut <= '0;
			gpioDir <= '0;
		end
		else if (op.wrLevel)
		begin
			case (op.sel)
				periphPkg::GPIOOUT: gpioOut <= op.wdata[31:0];
				periphPkg::GPIODIR: gpioDir <= op.wdata[31:0];
				periphPkg::GPIOSET: gpioOut <= gpioOut | op.wdata[31:0];
				periphPkg::GPIOCLR: gpioOut <= gpioOut & ~op.wdata[31:0];
				default:
				begin
				end
			endcase
		end
	end

	always_comb
	begin
		case (op.sel)
			periphPkg::GPIOOUT,
			periphPkg::GPIOSET,
			periphPkg::GPIOCLR: gpioRead = gpioOut;
			periphPkg::GPIODIR: gpioRead = gpioDir;
			default: gpioRead = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: uartTransmit.sv
/*
 UART transmitter.
 Byte FIFO fed by writes to the TX register, and an 8N1 serializer
 paced by a baud accumulator on the microsecond tick.
*/
`default_nettype none
`timescale 1ns/1ps
`include "periph_cfg.svh"

module uartTransmit
(
	input wire logic clock,
	input wire logic reset,
	input periphPkg::regOp_t op,
	input wire logic usTick,
	output logic uartTx,
	output logic txFull,
	output logic txEmpty
);

	localparam int Depth = `PERIPH_FIFO_DEPTH;
	localparam int PtrW = $clog2(Depth);
	localparam logic [PtrW:0] FullCount = (PtrW + 1)'(Depth);

	logic [7:0] fifoMem [Depth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0] count;
	logic push;
	logic pop;

	logic busy;
	logic [3:0] bitPos;
	logic [7:0] shiftReg;
	logic [15:0] baudAcc;
	logic [15:0] baudNext;
	logic baudStep;
	logic bitEnd;
	logic lineNext;

	assign txFull = (count == FullCount);
	// empty only once the last frame has left the shifter too
	assign txEmpty = (count == '0) && !busy;
	assign push = op.wrEdge && (op.sel == periphPkg::UARTTX) && !txFull;
	assign pop = !busy && (count != '0);

	assign {baudStep, baudNext} = {1'b0, baudAcc} + 17'(`PERIPH_BAUD_INC);
	assign bitEnd = busy && usTick && baudStep;

	always_ff @(posedge clock)
	begin
		if (push)
			fifoMem[wrPtr] <= op.wdata[7:0];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// bitPos 0 is the start bit, 1..8 data, 9 stop
	always_comb
	begin
		if (!busy || bitPos == 4'd9)
			lineNext = 1'b1;
		else if (bitPos == 4'd0)
			lineNext = 1'b0;
		else
			lineNext = shiftReg[0];
	end

	always_ff @(posedge clock)
	begin
		if (pop)
			shiftReg <= fifoMem[rdPtr];
		else if (bitEnd && bitPos != 4'd0)
			shiftReg <= {1'b0, shiftReg[7:1]};
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			bitPos <= '0;
			baudAcc <= '0;
			uartTx <= 1'b1;
		end
		else
		begin
			uartTx <= lineNext;
			if (pop)
			begin
				busy <= 1'b1;
				bitPos <= '0;
				baudAcc <= '0;
			end
			else if (busy && usTick)
			begin
				baudAcc <= baudNext;
				if (baudStep)
				begin
					if (bitPos == 4'd9)
						busy <= 1'b0;
					else
						bitPos <= bitPos + 4'd1;
				end
			end
		end
	end

	// a write into a full FIFO leaves the fill level alone
	assert property (@(posedge clock) disable iff (reset)
		(op.wrEdge && op.sel == periphPkg::UARTTX && txFull && !pop)
		|=> count == $past(count))
	else
		$error("TX push while full at %0t", $time);

endmodule

`default_nettype wire

// File: uartReceive.sv
/*
 UART receiver.
 Start-bit detect, mid-bit sampling of 8N1 frames and a byte FIFO
 popped by reads of the data register.
*/
`default_nettype none
`timescale 1ns/1ps
`include "periph_cfg.svh"

module uartReceive
(
	input wire logic clock,
	input wire logic reset,
	input periphPkg::regOp_t op,
	input wire logic usTick,
	input wire logic uartRx,
	output logic [7:0] rxHead,
	output logic rxFull,
	output logic rxReady
);

	localparam int Depth = `PERIPH_FIFO_DEPTH;
	localparam int PtrW = $clog2(Depth);
	localparam logic [PtrW:0] FullCount = (PtrW + 1)'(Depth);

	logic [7:0] fifoMem [Depth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0] count;
	logic push;
	logic pop;

	logic rxMeta;
	logic rxSync;
	logic rxLast;
	logic busy;
	logic [3:0] bitPos;
	logic [7:0] shiftReg;
	logic [7:0] rxByte;
	logic [15:0] baudAcc;
	logic [15:0] baudNext;
	logic baudStep;
	logic sample;
	logic byteDone;

	assign rxFull = (count == FullCount);
	assign rxReady = (count != '0);
	// empty FIFO reads as zero
	assign rxHead = rxReady ? fifoMem[rdPtr] : 8'h00;

	assign {baudStep, baudNext} = {1'b0, baudAcc} + 17'(`PERIPH_BAUD_INC);
	assign sample = busy && usTick && baudStep;
	assign byteDone = sample && (bitPos == 4'd8);
	assign rxByte = {rxSync, shiftReg[7:1]};

	assign push = byteDone && !rxFull;
	assign pop = op.rdEdge && (op.sel == periphPkg::UARTDATA) && rxReady;

	always_ff @(posedge clock)
	begin
		if (push)
			fifoMem[wrPtr] <= rxByte;
		if (sample && bitPos != 4'd0 && bitPos != 4'd9)
			shiftReg <= rxByte;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxLast <= 1'b1;
			busy <= 1'b0;
			bitPos <= '0;
			baudAcc <= '0;
		end
		else
		begin
			rxMeta <= uartRx;
			rxSync <= rxMeta;
			rxLast <= rxSync;
			if (!busy)
			begin
				// restart half a bit early so each carry lands mid-bit
				if (rxLast && !rxSync)
				begin
					busy <= 1'b1;
					bitPos <= '0;
					baudAcc <= 16'h8000;
				end
			end
			else if (usTick)
			begin
				baudAcc <= baudNext;
				if (baudStep)
				begin
					if (bitPos == 4'd0 && rxSync)
						busy <= 1'b0;
					else if (bitPos == 4'd9)
						// a low stop bit holds here until the line idles high
						busy <= !rxSync;
					else
						bitPos <= bitPos + 4'd1;
				end
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		(byteDone && rxFull && !pop) |=> count == $past(count))
	else
		$error("RX push while full at %0t", $time);

endmodule

`default_nettype wire

// File: mmioResult.sv
/*
 MMIO response stage.
 Read data mux, OK code and the one-cycle bounce interrupt word.
*/
`default_nettype none
`timescale 1ns/1ps

module mmioResult
(
	input wire logic clock,
	input wire logic reset,
	input periphPkg::regOp_t op,
	input wire logic [63:0] timer1MHz,
	input wire logic [31:0] gpioIn,
	input wire logic [31:0] gpioRead,
	input wire logic [7:0] rxHead,
	input wire logic txFull,
	input wire logic txEmpty,
	input wire logic rxFull,
	input wire logic rxReady,
	output mmioPkg::mmioRsp_t mmioRsp,
	output logic [63:0] bounceIrq
);

	periphPkg::uartStat_t uartStat;
	mmioPkg::okCode_t okNext;
	logic [63:0] rdData;
	logic [7:0] rxHold;
	logic rxPopRead;
	logic writable;

	assign uartStat = '{txFull: txFull, txEmpty: txEmpty, rxFull: rxFull, rxReady: rxReady};
	assign rxPopRead = op.rdEdge && (op.sel == periphPkg::UARTDATA);
	assign writable = op.sel inside {periphPkg::UARTTX, periphPkg::BOUNCE,
		periphPkg::GPIOOUT, periphPkg::GPIODIR, periphPkg::GPIOSET, periphPkg::GPIOCLR};

	// popped byte stays visible for the rest of a held read
	always_ff @(posedge clock)
	begin
		if (rxPopRead)
			rxHold <= rxHead;
	end

	always_comb
	begin
		case (op.sel)
			periphPkg::TIMERLO:
				rdData = {op.quad ? timer1MHz[63:32] : 32'h0, timer1MHz[31:0]};
			periphPkg::TIMERHI: rdData = {32'h0, timer1MHz[63:32]};
			periphPkg::UARTSTAT: rdData = {60'h0, uartStat};
			periphPkg::UARTDATA: rdData = {56'h0, rxPopRead ? rxHead : rxHold};
			periphPkg::GPIOIN: rdData = {32'h0, gpioIn};
			periphPkg::GPIOOUT,
			periphPkg::GPIODIR,
			periphPkg::GPIOSET,
			periphPkg::GPIOCLR: rdData = {32'h0, gpioRead};
			default: rdData = '0;
		endcase

		okNext = mmioPkg::READY;
		if ((op.sel != periphPkg::NONE && op.rdLevel) || (op.wrLevel && writable))
			okNext = mmioPkg::OK;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mmioRsp.ok <= mmioPkg::READY;
			mmioRsp.data <= '0;
			bounceIrq <= '0;
		end
		else
		begin
			mmioRsp.ok <= okNext;
			mmioRsp.data <= rdData;
			bounceIrq <= (op.wrEdge && op.sel == periphPkg::BOUNCE) ? op.wdata : 64'h0;
		end
	end

endmodule

`default_nettype wire

// File: mmioPeriph.sv
/*
 MMIO peripheral block.
 Timers, GPIO, UART and bounce interrupt behind one strobe bus port.
*/
`default_nettype none
`timescale 1ns/1ps

module mmioPeriph
(
	input wire logic clock,
	input wire logic reset,
	input mmioPkg::mmioReq_t mmioReq,
	output mmioPkg::mmioRsp_t mmioRsp,
	input wire logic [31:0] gpioIn,
	output logic [31:0] gpioOut,
	output logic [31:0] gpioDir,
	input wire logic uartRx,
	output logic uartTx,
	output logic [63:0] timer1MHz,
	output logic [63:0] timerCycles,
	output logic [63:0] bounceIrq
);

	periphPkg::regOp_t op;
	logic usTick;
	logic [31:0] gpioRead;
	logic [7:0] rxHead;
	logic txFull;
	logic txEmpty;
	logic rxFull;
	logic rxReady;

	mmioDecode decode (.clock(clock), .reset(reset), .mmioReq(mmioReq), .op(op));

	tickTimer timer
	(
		.clock(clock), .reset(reset), .usTick(usTick),
		.timer1MHz(timer1MHz), .timerCycles(timerCycles)
	);

	gpioPort gpio
	(
		.clock(clock), .reset(reset), .op(op),
		.gpioOut(gpioOut), .gpioDir(gpioDir), .gpioRead(gpioRead)
	);

	uartTransmit uartTxBlock
	(
		.clock(clock), .reset(reset), .op(op), .usTick(usTick),
		.uartTx(uartTx), .txFull(txFull), .txEmpty(txEmpty)
	);

	uartReceive uartRxBlock
	(
		.clock(clock), .reset(reset), .op(op), .usTick(usTick), .uartRx(uartRx),
		.rxHead(rxHead), .rxFull(rxFull), .rxReady(rxReady)
	);

	mmioResult result
	(
		.clock(clock), .reset(reset), .op(op), .timer1MHz(timer1MHz),
		.gpioIn(gpioIn), .gpioRead(gpioRead), .rxHead(rxHead),
		.txFull(txFull), .txEmpty(txEmpty), .rxFull(rxFull), .rxReady(rxReady),
		.mmioRsp(mmioRsp), .bounceIrq(bounceIrq)
	);

endmodule

`default_nettype wire

// File: tbMmioPeriph.sv
/*
 Testbench for the MMIO peripheral block.
 Bus read and write tasks, GPIO and timer checks, UART loopback with
 a frame monitor on the TX pin, and the bounce interrupt.
*/
`default_nettype none
`timescale 1ns/1ps
`include "periph_cfg.svh"

module tbMmioPeriph;

	// clocks per UART bit as microseconds per bit times clocks per microsecond
	localparam int BitClocks = (65536 / `PERIPH_BAUD_INC) * (65536 / `PERIPH_TICK_INC);

	logic clock;
	logic reset;
	mmioPkg::mmioReq_t mmioReq;
	mmioPkg::mmioRsp_t mmioRsp;
	logic [31:0] gpioIn;
	logic [31:0] gpioOut;
	logic [31:0] gpioDir;
	logic uartRx;
	logic uartTx;
	logic [63:0] timer1MHz;
	logic [63:0] timerCycles;
	logic [63:0] bounceIrq;

	int errorCount;
	int timeoutCount;
	bit timedOut;
	integer seed;
	logic [63:0] clockCount;
	logic [63:0] applyAt;
	logic [63:0] bounceAt;
	logic [63:0] bounceLast;
	int bounceCount;
	logic [7:0] expTx[$];
	logic [7:0] expRx[$];
	logic [31:0] refOut;
	logic [31:0] refDir;
	logic [63:0] timerForce;

	mmioPeriph UUT
	(
		.clock(clock), .reset(reset), .mmioReq(mmioReq), .mmioRsp(mmioRsp),
		.gpioIn(gpioIn), .gpioOut(gpioOut), .gpioDir(gpioDir),
		.uartRx(uartRx), .uartTx(uartTx),
		.timer1MHz(timer1MHz), .timerCycles(timerCycles), .bounceIrq(bounceIrq)
	);

	// loopback
	assign uartRx = uartTx;

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// clocks since reset
	always @(posedge clock)
	begin
		if (reset)
			clockCount <= '0;
		else
			clockCount <= clockCount + 64'd1;
	end

	always @(negedge clock)
	begin
		if (bounceIrq != 64'h0)
		begin
			bounceCount++;
			bounceLast = bounceIrq;
			bounceAt = clockCount;
		end
	end

	task automatic failCheck(input string msg);
		errorCount++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic reportTimeout(input string what);
		timeoutCount++;
		timedOut = 1'b1;
		$display("timeout: no progress while waiting for %s at %0t", what, $time);
	endtask

	assert property (@(posedge clock) disable iff (reset)
		bounceIrq != 64'h0 |=> bounceIrq == 64'h0)
	else
		failCheck("bounceIrq held for more than one cycle");

	assert property (@(posedge clock) disable iff (reset) mmioRsp.ok != mmioPkg::HOLD)
	else
		failCheck("HOLD code on the response");

	// samples uartTx at mid-bit, starting from the falling start edge
	initial
	begin : frameMonitor
		logic [7:0] seenByte;
		logic [7:0] want;
		forever
		begin
			@(negedge clock);
			if (!reset && uartTx == 1'b0)
			begin
				repeat (BitClocks / 2) @(negedge clock);
				assert (uartTx == 1'b0) else failCheck("start bit not low at mid-bit");
				for (int i = 0; i < 8; i++)
				begin
					repeat (BitClocks) @(negedge clock);
					seenByte[i] = uartTx;
				end
				repeat (BitClocks) @(negedge clock);
				assert (uartTx == 1'b1) else failCheck("stop bit not high at mid-bit");
				assert (expTx.size() != 0) else failCheck("frame sent with no byte expected");
				if (expTx.size() != 0)
				begin
					want = expTx.pop_front();
					assert (seenByte == want)
					else
						failCheck($sformatf("frame carried %h, expected %h", seenByte, want));
				end
			end
		end
	end

	// request held for 3 cycles from 2 ns after a rising edge
	task automatic busAccess(input logic [31:0] addr, input logic write, input logic quad,
		input logic [63:0] wdata, output logic [63:0] rdata, output mmioPkg::okCode_t ok);
		mmioReq.addr = addr;
		mmioReq.data = wdata;
		mmioReq.opm = '0;
		mmioReq.opm[mmioPkg::OPM_SIZE_HI:mmioPkg::OPM_SIZE_LO] =
			quad ? mmioPkg::SIZE_QUAD : 2'd2;
		if (write)
			mmioReq.opm[mmioPkg::OPM_WRITE] = 1'b1;
		else
			mmioReq.opm[mmioPkg::OPM_READ] = 1'b1;
		applyAt = clockCount;
		repeat (3) @(posedge clock);
		#2;
		rdata = mmioRsp.data;
		ok = mmioRsp.ok;
		mmioReq.opm = '0;
		// idle cycle so the next access starts with a fresh edge
		@(posedge clock);
		#2;
	endtask

	task automatic readReg(input logic [15:0] offset, input logic quad,
		output logic [63:0] data);
		mmioPkg::okCode_t ok;
		busAccess({4'h0, `PERIPH_PAGE, offset}, 1'b0, quad, 64'h0, data, ok);
		assert (ok == mmioPkg::OK) else failCheck($sformatf("read of %h not accepted", offset));
	endtask

	task automatic writeReg(input logic [15:0] offset, input logic [63:0] data);
		mmioPkg::okCode_t ok;
		logic [63:0] unused;
		busAccess({4'h0, `PERIPH_PAGE, offset}, 1'b1, 1'b0, data, unused, ok);
		assert (ok == mmioPkg::OK) else failCheck($sformatf("write of %h not accepted", offset));
	endtask

	task automatic checkAfterReset;
		logic [63:0] data;
		mmioPkg::okCode_t ok;
		assert (mmioRsp.ok == mmioPkg::READY && mmioRsp.data == 64'h0)
		else
			failCheck("response not idle after reset");
		assert (uartTx == 1'b1) else failCheck("uartTx not idle high after reset");
		assert (gpioOut == 32'h0 && gpioDir == 32'h0 && bounceIrq == 64'h0)
		else
			failCheck("GPIO or bounce outputs not zero after reset");
		readReg(`PERIPH_OFF_UARTSTAT, 1'b0, data);
		assert (data[2] == 1'b1 && data[0] == 1'b0)
		else
			failCheck($sformatf("status after reset is %h", data));
		// other page, then an unmapped offset
		busAccess(32'h0001_E000, 1'b0, 1'b0, 64'h0, data, ok);
		assert (ok == mmioPkg::READY && data == 64'h0) else failCheck("other page answered");
		busAccess({4'h0, `PERIPH_PAGE, 16'hE00C}, 1'b0, 1'b0, 64'h0, data, ok);
		assert (ok == mmioPkg::READY && data == 64'h0) else failCheck("unmapped offset answered");
	endtask

	task automatic checkGpioState;
		logic [63:0] data;
		assert (gpioOut == refOut && gpioDir == refDir)
		else
			failCheck($sformatf("GPIO pins %h/%h, expected %h/%h",
				gpioOut, gpioDir, refOut, refDir));
		readReg(`PERIPH_OFF_GPIOOUT, 1'b0, data);
		assert (data == {32'h0, refOut}) else failCheck($sformatf("GPIOOUT read %h", data));
		readReg(`PERIPH_OFF_GPIODIR, 1'b0, data);
		assert (data == {32'h0, refDir}) else failCheck($sformatf("GPIODIR read %h", data));
		readReg(`PERIPH_OFF_GPIOSET, 1'b0, data);
		assert (data == {32'h0, refOut}) else failCheck($sformatf("GPIOSET read %h", data));
	endtask

	task automatic checkGpio;
		logic [31:0] value;
		logic [63:0] data;
		for (int i = 0; i < 4; i++)
		begin
			value = $random(seed);
			writeReg(`PERIPH_OFF_GPIOOUT, {32'h0, value});
			refOut = value;
			value = $random(seed);
			writeReg(`PERIPH_OFF_GPIODIR, {32'h0, value});
			refDir = value;
			checkGpioState();
			value = $random(seed);
			writeReg(`PERIPH_OFF_GPIOSET, {32'h0, value});
			refOut = refOut | value;
			checkGpioState();
			value = $random(seed);
			writeReg(`PERIPH_OFF_GPIOCLR, {32'h0, value});
			refOut = refOut & ~value;
			checkGpioState();
		end
		gpioIn = $random(seed);
		readReg(`PERIPH_OFF_GPIOIN, 1'b0, data);
		assert (data == {32'h0, gpioIn}) else failCheck($sformatf("GPIOIN read %h", data));
	endtask

	task automatic checkTimers;
		logic [63:0] t0;
		logic [63:0] c0;
		logic [63:0] grown;
		logic [63:0] expected;
		logic [63:0] data;
		assert (timerCycles == clockCount)
		else
			failCheck($sformatf("timerCycles %0d, clocks %0d", timerCycles, clockCount));
		t0 = timer1MHz;
		c0 = clockCount;
		repeat (1000) @(posedge clock);
		#2;
		assert (timerCycles == clockCount)
		else
			failCheck($sformatf("timerCycles %0d, clocks %0d", timerCycles, clockCount));
		expected = (clockCount - c0) * `PERIPH_TICK_INC / 65536;
		grown = timer1MHz - t0;
		assert (grown + 1 >= expected && grown <= expected + 1)
		else
			failCheck($sformatf("timer1MHz grew %0d, expected %0d", grown, expected));
		// the high word never leaves zero in a short run, so a known one is held on the timer
		timerForce = {$random(seed), $random(seed)} | 64'h1_0000_0000;
		force UUT.timer1MHz = timerForce;
		readReg(`PERIPH_OFF_TIMERLO, 1'b1, data);
		assert (data == timerForce)
		else
			failCheck($sformatf("quad TIMERLO read %h, expected %h", data, timerForce));
		readReg(`PERIPH_OFF_TIMERLO, 1'b0, data);
		assert (data == {32'h0, timerForce[31:0]})
		else
			failCheck($sformatf("word TIMERLO read %h, expected %h", data, timerForce[31:0]));
		readReg(`PERIPH_OFF_TIMERHI, 1'b0, data);
		assert (data == {32'h0, timerForce[63:32]})
		else
			failCheck($sformatf("TIMERHI read %h, expected %h", data, timerForce[63:32]));
		release UUT.timer1MHz;
	endtask

	// polls status and reads bytes until count have come back and TX is idle
	task automatic drainUart(input int count);
		int received;
		logic [63:0] data;
		logic [63:0] startAt;
		logic [63:0] limit;
		logic [7:0] want;
		bit done;
		received = 0;
		done = 1'b0;
		startAt = clockCount;
		limit = (count + 2) * 20 * BitClocks;
		while (!done && !timedOut)
		begin
			readReg(`PERIPH_OFF_UARTSTAT, 1'b0, data);
			if (data[0])
			begin
				readReg(`PERIPH_OFF_UARTDATA, 1'b0, data);
				assert (expRx.size() != 0) else failCheck("byte received that was never sent");
				if (expRx.size() != 0)
				begin
					want = expRx.pop_front();
					assert (data == {56'h0, want})
					else
						failCheck($sformatf("UARTDATA read %h, expected %h", data, want));
				end
				received++;
			end
			else if (data[2] && received >= count)
				done = 1'b1;
			else if (clockCount - startAt > limit)
				reportTimeout("UART bytes to come back");
		end
		if (!timedOut)
		begin
			readReg(`PERIPH_OFF_UARTSTAT, 1'b0, data);
			assert (data[3:0] == 4'b0100)
			else
				failCheck($sformatf("status after drain is %h", data));
		end
	endtask

	task automatic checkLoopback;
		logic [7:0] value;
		for (int i = 0; i < 5; i++)
		begin
			value = $random(seed);
			expTx.push_back(value);
			expRx.push_back(value);
			writeReg(`PERIPH_OFF_UARTTX, {56'h0, value});
		end
		drainUart(5);
	endtask

	task automatic checkBackPressure;
		logic [7:0] value;
		logic [63:0] data;
		// one byte leaves for the shifter, eight fill the FIFO, the rest drop
		for (int i = 0; i < 12; i++)
		begin
			value = $random(seed);
			if (i < 9)
			begin
				expTx.push_back(value);
				expRx.push_back(value);
			end
			writeReg(`PERIPH_OFF_UARTTX, {56'h0, value});
		end
		readReg(`PERIPH_OFF_UARTSTAT, 1'b0, data);
		assert (data[3] == 1'b1 && data[2] == 1'b0)
		else
			failCheck($sformatf("status after 12 writes is %h", data));
		drainUart(9);
	endtask

	task automatic checkBounce;
		logic [63:0] value;
		value = {$random(seed), $random(seed)} | 64'h1;
		bounceCount = 0;
		writeReg(`PERIPH_OFF_BOUNCE, value);
		repeat (4) @(posedge clock);
		#2;
		// sampled on the first edge after applyAt, then two cycles of latency
		assert (bounceCount == 1 && bounceLast == value && bounceAt == applyAt + 3)
		else
			failCheck($sformatf("bounce seen %0d times, value %h at %0d, applied at %0d",
				bounceCount, bounceLast, bounceAt, applyAt));
	endtask

	initial
	begin
		reset = 1'b1;
		mmioReq = '0;
		gpioIn = '0;
		seed = 32'hff6b0433;
		errorCount = 0;
		timeoutCount = 0;
		timedOut = 1'b0;
		bounceCount = 0;
		refOut = '0;
		refDir = '0;
		repeat (5) @(posedge clock);
		#2;
		reset = 1'b0;
		checkAfterReset();
		checkGpio();
		checkTimers();
		if (!timedOut)
			checkLoopback();
		if (!timedOut)
			checkBackPressure();
		if (!timedOut)
			checkBounce();
		if (!timedOut)
		begin
			assert (expTx.size() == 0) else failCheck("expected frames never seen on uartTx");
		end
		$display("errors: %0d failed checks, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
mmioPkg.sv
periphPkg.sv
mmioDecode.sv
tickTimer.sv
gpioPort.sv
uartTransmit.sv
uartReceive.sv
mmioResult.sv
mmioPeriph.sv
tbMmioPeriph.sv
